// File: design/spw_tx_params.svh
//------------------------------
// SpaceWire transmitter constants
// Character widths, lengths, control codes and the
// flow-control credit limits
//------------------------------
`ifndef SPW_TX_PARAMS_SVH
`define SPW_TX_PARAMS_SVH

// N-char layout, bit 8 is the control flag
`define SPW_DATA_W       8
`define SPW_NCHAR_W      9

// Character lengths in line bits, EEP shares the EOP length
`define SPW_LEN_NULL     8
`define SPW_LEN_FCT      4
`define SPW_LEN_EOP      4
`define SPW_LEN_DATA     10

// Control codes, sent LSB first after the flag
`define SPW_CODE_FCT     2'b00
`define SPW_CODE_EOP     2'b01
`define SPW_CODE_EEP     2'b10
`define SPW_CODE_ESC     2'b11

// Flow control
`define SPW_CREDIT_STEP  8
`define SPW_CREDIT_MAX   56
`define SPW_FCT_OWED_MAX 7

`endif

// File: design/spw_tx_pkg.sv
//------------------------------
// SpaceWire transmitter types
// Character kinds and link states
//------------------------------
`default_nettype none

package spw_tx_pkg;

	// Character on the line
	typedef enum logic [2:0] {
		NULL,
		FCT,
		EOP,
		EEP,
		DATA
	} char_kind_e;

	// Link start-up sequence
	typedef enum logic [1:0] {
		START,
		NULLS,
		NULL_FCT,
		FULL
	} link_state_e;

endpackage

`default_nettype wire

// File: design/spw_tx_credit.sv
//------------------------------
// SpaceWire TX flow control
// Receive credit from incoming FCTs and the count of
// FCTs this end still has to send
//------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "spw_tx_params.svh"

module spw_tx_credit (
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       gotfct_tx_i,
	input  logic       send_fct_now_i,
	input  logic       nchar_sent_i,
	input  logic       fct_sent_i,
	output logic       credit_avail_o,
	output logic [2:0] fct_owed_o
);

	localparam int CREDIT_W = $clog2(`SPW_CREDIT_MAX + 1);
	localparam logic [CREDIT_W:0] CREDIT_STEP = `SPW_CREDIT_STEP;
	localparam logic [CREDIT_W:0] CREDIT_MAX = `SPW_CREDIT_MAX;
	localparam logic [3:0] OWED_MAX = `SPW_FCT_OWED_MAX;

	logic                gotfct_q;
	logic                send_fct_now_q;
	logic                gotfct_rise;
	logic                fct_now_rise;
	logic [CREDIT_W-1:0] credit_q;
	logic [CREDIT_W:0]   credit_sum;
	logic [3:0]          owed_sum;

	// Only rising edges count
	assign gotfct_rise  = gotfct_tx_i & ~gotfct_q;
	assign fct_now_rise = send_fct_now_i & ~send_fct_now_q;

	// One extra bit so the ceiling check sees the carry
	assign credit_sum = {1'b0, credit_q} + (gotfct_rise ? CREDIT_STEP : '0)
		- {{CREDIT_W{1'b0}}, nchar_sent_i};
	assign owed_sum = {1'b0, fct_owed_o} + {3'b000, fct_now_rise}
		- {3'b000, fct_sent_i};

	assign credit_avail_o = (credit_q != '0);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			gotfct_q       <= 1'b0;
			send_fct_now_q <= 1'b0;
			credit_q       <= '0;
			fct_owed_o     <= OWED_MAX[2:0];
		end
		else
		begin
			gotfct_q       <= gotfct_tx_i;
			send_fct_now_q <= send_fct_now_i;

			// Saturate at the credit ceiling
			if (credit_sum > CREDIT_MAX)
			begin
				credit_q <= CREDIT_MAX[CREDIT_W-1:0];
			end
			else
			begin
				credit_q <= credit_sum[CREDIT_W-1:0];
			end

			if (owed_sum > OWED_MAX)
			begin
				fct_owed_o <= OWED_MAX[2:0];
			end
			else
			begin
				fct_owed_o <= owed_sum[2:0];
			end
		end
	end

	//------------------------------
	// Checks
	//------------------------------
	a_credit_ceiling: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		{1'b0, credit_q} <= CREDIT_MAX);

	// An N-char may only have been started with credit in hand
	a_sent_with_credit: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		nchar_sent_i |-> credit_q != '0);

endmodule

`default_nettype wire

// File: design/spw_tx_link_fsm.sv
//------------------------------
// SpaceWire TX link state machine
// Walks START, NULLS, NULL_FCT and FULL and picks the
// character sent at each boundary
//------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "spw_tx_params.svh"

module spw_tx_link_fsm (
	input  logic                     pclk_tx,
	input  logic                     enable_tx,
	input  logic                     send_null_tx_i,
	input  logic                     send_fct_tx_i,
	input  logic                     txwrite_tx_i,
	input  logic                     credit_avail_i,
	input  logic                     char_done_i,
	input  logic                     shift_idle_i,
	input  logic [2:0]               fct_owed_i,
	input  logic [`SPW_NCHAR_W-1:0]  data_tx_i,
	output logic                     char_start_o,
	output logic                     nchar_sent_o,
	output logic                     fct_sent_o,
	output logic                     ready_tx_data_o,
	output spw_tx_pkg::char_kind_e   char_kind_o,
	output logic [`SPW_NCHAR_W-1:0]  nchar_o
);

	spw_tx_pkg::link_state_e state_q;
	spw_tx_pkg::link_state_e state_d;
	spw_tx_pkg::char_kind_e  sending_q;
	spw_tx_pkg::char_kind_e  nchar_kind;
	logic                    boundary;
	logic                    sending_nchar;
	logic                    fct_due;
	logic                    nchar_ok;

	assign boundary      = char_done_i | shift_idle_i;
	assign sending_nchar = sending_q inside {spw_tx_pkg::EOP, spw_tx_pkg::EEP, spw_tx_pkg::DATA};

	// End-of-character strobes
	assign nchar_sent_o    = char_done_i & sending_nchar;
	assign fct_sent_o      = char_done_i & (sending_q == spw_tx_pkg::FCT);
	assign ready_tx_data_o = char_done_i & sending_nchar;

	// The FCT finishing now is still in the owed count
	assign fct_due = fct_sent_o ? (fct_owed_i > 3'd1) : (fct_owed_i != 3'd0);

	// Source only updates data_tx_i after the ready pulse
	assign nchar_ok = txwrite_tx_i & credit_avail_i & ~ready_tx_data_o;

	assign nchar_kind = !data_tx_i[`SPW_NCHAR_W-1] ? spw_tx_pkg::DATA :
		(data_tx_i[1:0] == 2'b00) ? spw_tx_pkg::EOP : spw_tx_pkg::EEP;

	always_comb
	begin
		state_d      = state_q;
		char_start_o = 1'b0;
		char_kind_o  = spw_tx_pkg::NULL;
		case (state_q)
			spw_tx_pkg::START:
			begin
				if (send_null_tx_i)
				begin
					state_d = spw_tx_pkg::NULLS;
				end
			end
			spw_tx_pkg::NULLS:
			begin
				char_start_o = boundary;
				if (boundary && send_fct_tx_i)
				begin
					state_d = spw_tx_pkg::NULL_FCT;
				end
			end
			spw_tx_pkg::NULL_FCT:
			begin
				char_start_o = boundary;
				if (fct_due)
				begin
					char_kind_o = spw_tx_pkg::FCT;
				end
				if (boundary && send_fct_tx_i && credit_avail_i)
				begin
					state_d = spw_tx_pkg::FULL;
				end
			end
			default:
			begin
				// FULL, FCT first, then N-char, then NULL
				char_start_o = boundary;
				if (fct_due)
				begin
					char_kind_o = spw_tx_pkg::FCT;
				end
				else if (nchar_ok)
				begin
					char_kind_o = nchar_kind;
				end
			end
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state_q   <= spw_tx_pkg::START;
			sending_q <= spw_tx_pkg::NULL;
		end
		else
		begin
			state_q <= state_d;
			if (char_start_o)
			begin
				sending_q <= char_kind_o;
			end
		end
	end

	// Held for the whole N-char
	always_ff @(posedge pclk_tx)
	begin
		if (char_start_o && char_kind_o inside {spw_tx_pkg::EOP, spw_tx_pkg::EEP,
			spw_tx_pkg::DATA})
		begin
			nchar_o <= data_tx_i;
		end
	end

	a_start_on_boundary: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		char_start_o |-> (char_done_i || shift_idle_i));

endmodule

`default_nettype wire

// File: design/spw_tx_char_shift.sv
//------------------------------
// SpaceWire TX character serializer
// Parity, flag, then code or data bits, LSB first
// Parity covers the previous character's bits
//------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "spw_tx_params.svh"

module spw_tx_char_shift (
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  logic                    char_start_i,
	input  spw_tx_pkg::char_kind_e  char_kind_i,
	input  logic [`SPW_NCHAR_W-1:0] nchar_i,
	output logic                    bit_o,
	output logic                    bit_valid_o,
	output logic                    char_done_o,
	output logic                    shift_idle_o
);

	localparam int VEC_W = `SPW_LEN_DATA;
	localparam int CNT_W = $clog2(VEC_W);

	// Inner parity between ESC and FCT of a NULL
	localparam logic NULL_PAR = ~(^`SPW_CODE_ESC ^ 1'b1);

	spw_tx_pkg::char_kind_e kind_q;
	logic                   active_q;
	logic [CNT_W-1:0]       cnt_q;
	logic                   par_q;
	logic [CNT_W-1:0]       len_cur;
	logic [`SPW_DATA_W-1:0] last_bits;
	logic                   par_new;
	logic [VEC_W-1:0]       char_vec;

	function automatic logic [CNT_W-1:0] char_len(input spw_tx_pkg::char_kind_e kind);
		case (kind)
			spw_tx_pkg::NULL: return CNT_W'(`SPW_LEN_NULL);
			spw_tx_pkg::FCT:  return CNT_W'(`SPW_LEN_FCT);
			spw_tx_pkg::DATA: return CNT_W'(`SPW_LEN_DATA);
			default:          return CNT_W'(`SPW_LEN_EOP);
		endcase
	endfunction

	// A NULL ends in an FCT code
	function automatic logic [1:0] char_code(input spw_tx_pkg::char_kind_e kind);
		case (kind)
			spw_tx_pkg::NULL: return `SPW_CODE_FCT;
			spw_tx_pkg::FCT:  return `SPW_CODE_FCT;
			spw_tx_pkg::EOP:  return `SPW_CODE_EOP;
			default:          return `SPW_CODE_EEP;
		endcase
	endfunction

	//------------------------------
	// Parity
	//------------------------------
	// kind_q is the character in flight, or the last one sent;
	// nchar_i still holds its data until the next N-char starts
	always_comb
	begin
		if (kind_q == spw_tx_pkg::DATA)
		begin
			last_bits = nchar_i[`SPW_DATA_W-1:0];
		end
		else
		begin
			last_bits = {{(`SPW_DATA_W - 2){1'b0}}, char_code(kind_q)};
		end
	end

	assign par_new = ~(^last_bits ^ (char_kind_i != spw_tx_pkg::DATA));

	//------------------------------
	// Bit selection
	//------------------------------
	always_comb
	begin
		case (kind_q)
			spw_tx_pkg::DATA:
				char_vec = {nchar_i[`SPW_DATA_W-1:0], 1'b0, par_q};
			spw_tx_pkg::NULL:
				char_vec = {2'b00, `SPW_CODE_FCT, 1'b1, NULL_PAR, `SPW_CODE_ESC, 1'b1, par_q};
			default:
				char_vec = {{(VEC_W - 4){1'b0}}, char_code(kind_q), 1'b1, par_q};
		endcase
	end

	assign len_cur      = char_len(kind_q);
	assign bit_o        = char_vec[cnt_q];
	assign bit_valid_o  = active_q;
	assign char_done_o  = active_q & (cnt_q == len_cur - CNT_W'(1));
	assign shift_idle_o = ~active_q;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			active_q <= 1'b0;
			cnt_q    <= '0;
			kind_q   <= spw_tx_pkg::NULL;
			par_q    <= 1'b0;
		end
		else if (char_start_i)
		begin
			active_q <= 1'b1;
			cnt_q    <= '0;
			kind_q   <= char_kind_i;
			par_q    <= par_new;
		end
		else if (char_done_o)
		begin
			active_q <= 1'b0;
		end
		else if (active_q)
		begin
			cnt_q <= cnt_q + CNT_W'(1);
		end
	end

	a_cnt_in_char: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		active_q |-> cnt_q < char_len(kind_q));

endmodule

`default_nettype wire

// File: design/spw_tx_ds_encoder.sv
//------------------------------
// SpaceWire data-strobe encoder
// Registered D and S line outputs
//------------------------------
`default_nettype none
`timescale 1ns/1ns

module spw_tx_ds_encoder (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic bit_i,
	input  logic bit_valid_i,
	output logic tx_dout_o,
	output logic tx_sout_o
);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			tx_dout_o <= 1'b0;
			tx_sout_o <= 1'b0;
		end
		else if (bit_valid_i)
		begin
			tx_dout_o <= bit_i;
			// Strobe moves when data does not
			if (bit_i == tx_dout_o)
			begin
				tx_sout_o <= ~tx_sout_o;
			end
		end
	end

	// One line transition per bit
	a_ds_one_edge: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		bit_valid_i |=> ($changed(tx_dout_o) != $changed(tx_sout_o)));

endmodule

`default_nettype wire

// File: design/spw_tx.sv
//------------------------------
// SpaceWire link transmitter
// Flow control, link FSM, serializer and DS encoder
//------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "spw_tx_params.svh"

module spw_tx (
	input  logic                    pclk_tx,
	input  logic                    enable_tx,
	input  logic                    txwrite_tx,
	input  logic                    send_null_tx,
	input  logic                    send_fct_tx,
	input  logic                    gotfct_tx,
	input  logic                    send_fct_now,
	input  logic [`SPW_NCHAR_W-1:0] data_tx_i,
	output logic                    tx_dout_o,
	output logic                    tx_sout_o,
	output logic                    ready_tx_data_o
);

	logic                    credit_avail;
	logic [2:0]              fct_owed;
	logic                    nchar_sent;
	logic                    fct_sent;
	logic                    char_start;
	spw_tx_pkg::char_kind_e  char_kind;
	logic [`SPW_NCHAR_W-1:0] nchar;
	logic                    char_done;
	logic                    shift_idle;
	logic                    tx_bit;
	logic                    bit_valid;

	spw_tx_credit u_credit (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.gotfct_tx_i    (gotfct_tx),
		.send_fct_now_i (send_fct_now),
		.nchar_sent_i   (nchar_sent),
		.fct_sent_i     (fct_sent),
		.credit_avail_o (credit_avail),
		.fct_owed_o     (fct_owed)
	);

	spw_tx_link_fsm u_link_fsm (
		.pclk_tx         (pclk_tx),
		.enable_tx       (enable_tx),
		.send_null_tx_i  (send_null_tx),
		.send_fct_tx_i   (send_fct_tx),
		.txwrite_tx_i    (txwrite_tx),
		.credit_avail_i  (credit_avail),
		.char_done_i     (char_done),
		.shift_idle_i    (shift_idle),
		.fct_owed_i      (fct_owed),
		.data_tx_i       (data_tx_i),
		.char_start_o    (char_start),
		.nchar_sent_o    (nchar_sent),
		.fct_sent_o      (fct_sent),
		.ready_tx_data_o (ready_tx_data_o),
		.char_kind_o     (char_kind),
		.nchar_o         (nchar)
	);

	spw_tx_char_shift u_char_shift (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.char_start_i (char_start),
		.char_kind_i  (char_kind),
		.nchar_i      (nchar),
		.bit_o        (tx_bit),
		.bit_valid_o  (bit_valid),
		.char_done_o  (char_done),
		.shift_idle_o (shift_idle)
	);

	spw_tx_ds_encoder u_ds_encoder (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.bit_i       (tx_bit),
		.bit_valid_i (bit_valid),
		.tx_dout_o   (tx_dout_o),
		.tx_sout_o   (tx_sout_o)
	);

endmodule

`default_nettype wire

// File: verif/spw_tx_ds_monitor.sv
//------------------------------
// SpaceWire DS line monitor
// Recovers bits from the data-strobe pair, frames
// characters and checks their odd parity
//------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "spw_tx_params.svh"

module spw_tx_ds_monitor (
	input  logic                   pclk_tx,
	input  logic                   enable_tx,
	input  logic                   tx_dout_i,
	input  logic                   tx_sout_i,
	output logic                   char_valid_o,
	output spw_tx_pkg::char_kind_e char_kind_o,
	output logic [`SPW_DATA_W-1:0] char_data_o,
	output logic                   bad_char_o
);

	logic                      xor_q;
	logic [`SPW_LEN_DATA-1:0]  bits_q;
	int                        cnt_q;
	logic [`SPW_DATA_W-1:0]    last_q;
	logic                      esc_q;

	// Line outputs settle well before the falling edge
	always @(negedge pclk_tx or negedge enable_tx)
	begin : take_bit
		logic [`SPW_LEN_DATA-1:0] nb;
		int                       n;
		logic [1:0]               code;
		if (!enable_tx)
		begin
			xor_q        <= 1'b0;
			bits_q       <= '0;
			cnt_q        <= 0;
			last_q       <= '0;
			esc_q        <= 1'b0;
			char_valid_o <= 1'b0;
			char_kind_o  <= spw_tx_pkg::NULL;
			char_data_o  <= '0;
			bad_char_o   <= 1'b0;
		end
		else
		begin
			char_valid_o <= 1'b0;
			bad_char_o   <= 1'b0;
			xor_q        <= tx_dout_i ^ tx_sout_i;
			if ((tx_dout_i ^ tx_sout_i) != xor_q)
			begin
				nb = bits_q;
				nb[cnt_q] = tx_dout_i;
				n = cnt_q + 1;
				code = nb[3:2];
				if ((n == `SPW_LEN_FCT && nb[1]) || n == `SPW_LEN_DATA)
				begin
					cnt_q  <= 0;
					bits_q <= '0;
					// Parity, flag and previous bits give an odd total
					bad_char_o <= ~(nb[0] ^ nb[1] ^ (^last_q));
					if (!nb[1])
					begin
						last_q       <= nb[`SPW_LEN_DATA-1:2];
						char_valid_o <= 1'b1;
						char_kind_o  <= spw_tx_pkg::DATA;
						char_data_o  <= nb[`SPW_LEN_DATA-1:2];
						esc_q        <= 1'b0;
						if (esc_q)
						begin
							bad_char_o <= 1'b1;
						end
					end
					else if (code == `SPW_CODE_ESC)
					begin
						last_q <= {{(`SPW_DATA_W - 2){1'b0}}, code};
						esc_q  <= 1'b1;
						if (esc_q)
						begin
							bad_char_o <= 1'b1;
						end
					end
					else
					begin
						last_q       <= {{(`SPW_DATA_W - 2){1'b0}}, code};
						esc_q        <= 1'b0;
						char_valid_o <= 1'b1;
						char_data_o  <= '0;
						if (esc_q)
						begin
							// ESC then FCT makes a NULL
							char_kind_o <= spw_tx_pkg::NULL;
							if (code != `SPW_CODE_FCT)
							begin
								bad_char_o <= 1'b1;
							end
						end
						else if (code == `SPW_CODE_FCT)
						begin
							char_kind_o <= spw_tx_pkg::FCT;
						end
						else if (code == `SPW_CODE_EOP)
						begin
							char_kind_o <= spw_tx_pkg::EOP;
						end
						else
						begin
							char_kind_o <= spw_tx_pkg::EEP;
						end
					end
				end
				else
				begin
					bits_q <= nb;
					cnt_q  <= n;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/spw_tx_tb.sv
//------------------------------
// SpaceWire transmitter testbench
// Link start-up, FCT handling, N-char stream and
// the receive-credit limit
//------------------------------
`default_nettype none
`timescale 1ns/1ns
`include "spw_tx_params.svh"

module spw_tx_tb;

	localparam int CLK_PERIOD = 4;
	localparam int N_CHARS    = 20;
	localparam int N_FIRST    = 8;
	// One N-char plus the NULL that follows it
	localparam int SLOT        = `SPW_LEN_DATA + `SPW_LEN_NULL;
	localparam int FEED_BUDGET = (N_FIRST + 4) * SLOT;
	localparam int WAIT_LIMIT  = 24 * `SPW_LEN_NULL;
	localparam int WATCHDOG_NS = (4 * N_CHARS * SLOT + 40 * WAIT_LIMIT) * CLK_PERIOD;

	logic                    pclk_tx;
	logic                    enable_tx;
	logic                    txwrite_tx;
	logic                    send_null_tx;
	logic                    send_fct_tx;
	logic                    gotfct_tx;
	logic                    send_fct_now;
	logic [`SPW_NCHAR_W-1:0] data_tx_i;
	logic                    tx_dout_o;
	logic                    tx_sout_o;
	logic                    ready_tx_data_o;

	logic                    mon_valid;
	spw_tx_pkg::char_kind_e  mon_kind;
	logic [`SPW_DATA_W-1:0]  mon_data;
	logic                    mon_bad;

	// Stream test takes the first N_FIRST, the credit test the rest
	spw_tx_pkg::char_kind_e kind_tab [N_CHARS] = '{
		spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::EOP,
		spw_tx_pkg::DATA, spw_tx_pkg::EEP, spw_tx_pkg::DATA, spw_tx_pkg::EOP,
		spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::EOP,
		spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::DATA,
		spw_tx_pkg::EEP, spw_tx_pkg::DATA, spw_tx_pkg::DATA, spw_tx_pkg::EOP
	};
	logic [`SPW_NCHAR_W-1:0] stim_tab [N_CHARS];

	spw_tx_pkg::char_kind_e  log_kind [$];
	logic [`SPW_DATA_W-1:0]  log_data [$];

	logic [31:0] lcg_state;
	int          checks;
	int          errors;
	int          ds_errors;
	int          test_err0;
	int          ready_pulses;
	logic        flowing;
	logic        d_prev;
	logic        s_prev;

	spw_tx uut (
		.pclk_tx         (pclk_tx),
		.enable_tx       (enable_tx),
		.txwrite_tx      (txwrite_tx),
		.send_null_tx    (send_null_tx),
		.send_fct_tx     (send_fct_tx),
		.gotfct_tx       (gotfct_tx),
		.send_fct_now    (send_fct_now),
		.data_tx_i       (data_tx_i),
		.tx_dout_o       (tx_dout_o),
		.tx_sout_o       (tx_sout_o),
		.ready_tx_data_o (ready_tx_data_o)
	);

	spw_tx_ds_monitor u_monitor (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.tx_dout_i    (tx_dout_o),
		.tx_sout_i    (tx_sout_o),
		.char_valid_o (mon_valid),
		.char_kind_o  (mon_kind),
		.char_data_o  (mon_data),
		.bad_char_o   (mon_bad)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever #(CLK_PERIOD / 2) pclk_tx = ~pclk_tx;
	end

	//------------------------------
	// Helpers
	//------------------------------
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic is_nchar(input spw_tx_pkg::char_kind_e k);
		return k == spw_tx_pkg::DATA || k == spw_tx_pkg::EOP || k == spw_tx_pkg::EEP;
	endfunction

	function automatic int count_kind(input spw_tx_pkg::char_kind_e k);
		int n;
		n = 0;
		foreach (log_kind[i])
		begin
			if (log_kind[i] == k)
			begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic int count_nchars();
		return count_kind(spw_tx_pkg::DATA) + count_kind(spw_tx_pkg::EOP)
			+ count_kind(spw_tx_pkg::EEP);
	endfunction

	task automatic check_true(input logic ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			$display("ERR %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic build_table();
		logic [31:0] r;
		int          i;
		for (i = 0; i < N_CHARS; i++)
		begin
			r = next_rand();
			case (kind_tab[i])
				spw_tx_pkg::EOP: stim_tab[i] = 9'h100;
				spw_tx_pkg::EEP: stim_tab[i] = 9'h101;
				default:         stim_tab[i] = {1'b0, r[23:16]};
			endcase
		end
	endtask

	task automatic clear_log();
		log_kind.delete();
		log_data.delete();
		ready_pulses = 0;
	endtask

	task automatic pulse_gotfct();
		@(posedge pclk_tx);
		gotfct_tx <= 1'b1;
		@(posedge pclk_tx);
		gotfct_tx <= 1'b0;
	endtask

	task automatic pulse_fct_now();
		@(posedge pclk_tx);
		send_fct_now <= 1'b1;
		@(posedge pclk_tx);
		send_fct_now <= 1'b0;
	endtask

	// Decoded characters are pushed on rising edges
	task automatic wait_for_chars(input int n, input logic nchar_only);
		int cycles;
		int seen;
		cycles = 0;
		seen = nchar_only ? count_nchars() : log_kind.size();
		while (seen < n && cycles < WAIT_LIMIT)
		begin
			@(negedge pclk_tx);
			cycles++;
			seen = nchar_only ? count_nchars() : log_kind.size();
		end
		if (seen < n)
		begin
			$display("Timeout after %0d cycles waiting for %0d characters, only %0d decoded",
				cycles, n, seen);
			errors++;
		end
	endtask

	// Source side, next character goes out after each ready pulse
	task automatic feed_source(input int first, input int last, input int budget,
		output int sent);
		int idx;
		int cycles;
		idx = first;
		cycles = 0;
		sent = 0;
		@(posedge pclk_tx);
		txwrite_tx <= 1'b1;
		data_tx_i  <= stim_tab[idx];
		while (idx < last && cycles < budget)
		begin
			@(negedge pclk_tx);
			cycles++;
			if (ready_tx_data_o)
			begin
				idx++;
				sent++;
				@(posedge pclk_tx);
				if (idx < last)
				begin
					data_tx_i <= stim_tab[idx];
				end
				else
				begin
					txwrite_tx <= 1'b0;
				end
			end
		end
	endtask

	task automatic compare_nchars(input int first, input int count);
		int j;
		j = first;
		foreach (log_kind[i])
		begin
			if (is_nchar(log_kind[i]))
			begin
				if (j < first + count)
				begin
					check_true(log_kind[i] == kind_tab[j], $sformatf(
						"N-char %0d has kind %0d, expected %0d", j, log_kind[i], kind_tab[j]));
					if (kind_tab[j] == spw_tx_pkg::DATA)
					begin
						check_true(log_data[i] == stim_tab[j][`SPW_DATA_W-1:0], $sformatf(
							"N-char %0d data %02h, expected %02h", j, log_data[i],
							stim_tab[j][`SPW_DATA_W-1:0]));
					end
				end
				j++;
			end
		end
		check_true(j == first + count, $sformatf("%0d N-chars decoded, expected %0d",
			j - first, count));
	endtask

	task automatic report_test(input int num, input string title);
		$display("Test %0d %s: %0d errors", num, title, errors - test_err0);
		test_err0 = errors;
	endtask

	//------------------------------
	// Monitor log and line checks
	//------------------------------
	always @(posedge pclk_tx)
	begin
		if (mon_valid)
		begin
			log_kind.push_back(mon_kind);
			log_data.push_back(mon_data);
		end
		if (mon_valid || mon_bad)
		begin
			check_true(!mon_bad, "decoded character has bad parity or an illegal escape");
		end
	end

	// Once bits flow, every cycle carries one bit
	always @(negedge pclk_tx)
	begin
		if (enable_tx === 1'b1)
		begin
			if (ready_tx_data_o === 1'b1)
			begin
				ready_pulses++;
			end
			if (flowing || tx_dout_o != d_prev || tx_sout_o != s_prev)
			begin
				flowing <= 1'b1;
				checks++;
				assert ((tx_dout_o != d_prev) != (tx_sout_o != s_prev))
				else
				begin
					$display("ERR %0t ns: D and S did not change one at a time", $time);
					errors++;
					ds_errors++;
				end
			end
			d_prev <= tx_dout_o;
			s_prev <= tx_sout_o;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	//------------------------------
	// Test sequence
	//------------------------------
	initial
	begin : main_seq
		int k;
		int sent;
		int resume;
		lcg_state    = 32'h5e0f360b;
		checks       = 0;
		errors       = 0;
		ds_errors    = 0;
		test_err0    = 0;
		ready_pulses = 0;
		flowing      = 1'b0;
		d_prev       = 1'b0;
		s_prev       = 1'b0;
		enable_tx    <= 1'b0;
		txwrite_tx   <= 1'b0;
		send_null_tx <= 1'b0;
		send_fct_tx  <= 1'b0;
		gotfct_tx    <= 1'b0;
		send_fct_now <= 1'b0;
		data_tx_i    <= '0;
		build_table();
		repeat (8) @(posedge pclk_tx);
		enable_tx <= 1'b1;

		// Link held in START
		repeat (4 * `SPW_LEN_NULL)
		begin
			@(negedge pclk_tx);
			check_true(!tx_dout_o && !tx_sout_o && !ready_tx_data_o,
				"line or ready active before send_null_tx");
		end
		@(posedge pclk_tx);
		send_null_tx <= 1'b1;
		wait_for_chars(6, 1'b0);
		check_true(log_kind.size() > 0 && count_kind(spw_tx_pkg::NULL) == log_kind.size(),
			"characters other than NULL in the NULLS state");
		report_test(1, "NULLs after send_null_tx");

		clear_log();
		@(posedge pclk_tx);
		send_fct_tx <= 1'b1;
		wait_for_chars(14, 1'b0);
		check_true(count_kind(spw_tx_pkg::FCT) == `SPW_FCT_OWED_MAX, $sformatf(
			"%0d FCTs after send_fct_tx, expected %0d", count_kind(spw_tx_pkg::FCT),
			`SPW_FCT_OWED_MAX));
		for (k = 0; k < 3; k++)
		begin
			clear_log();
			pulse_fct_now();
			wait_for_chars(4, 1'b0);
			check_true(count_kind(spw_tx_pkg::FCT) == 1, $sformatf(
				"%0d FCTs after send_fct_now edge %0d, expected 1",
				count_kind(spw_tx_pkg::FCT), k));
		end
		report_test(3, "initial and requested FCTs");

		clear_log();
		pulse_gotfct();
		feed_source(0, N_FIRST, FEED_BUDGET, sent);
		check_true(sent == N_FIRST, $sformatf("%0d ready pulses, expected %0d", sent, N_FIRST));
		wait_for_chars(N_FIRST, 1'b1);
		compare_nchars(0, N_FIRST);
		check_true(ready_pulses == N_FIRST, $sformatf(
			"%0d ready pulses in total, expected %0d", ready_pulses, N_FIRST));
		report_test(4, "N-char stream in order");

		clear_log();
		pulse_gotfct();
		feed_source(N_FIRST, N_CHARS, FEED_BUDGET, sent);
		check_true(sent == `SPW_CREDIT_STEP, $sformatf(
			"%0d ready pulses on one FCT, expected %0d", sent, `SPW_CREDIT_STEP));
		check_true(count_nchars() == `SPW_CREDIT_STEP, $sformatf(
			"%0d N-chars on one FCT, expected %0d", count_nchars(), `SPW_CREDIT_STEP));
		check_true(log_kind.size() > 0 && log_kind[$] == spw_tx_pkg::NULL,
			"no NULLs after credit ran out");
		resume = N_FIRST + sent;
		pulse_gotfct();
		feed_source(resume, N_CHARS, FEED_BUDGET, sent);
		check_true(sent == N_CHARS - resume, $sformatf(
			"%0d ready pulses after second FCT, expected %0d", sent, N_CHARS - resume));
		wait_for_chars(N_CHARS - N_FIRST, 1'b1);
		compare_nchars(N_FIRST, N_CHARS - N_FIRST);
		check_true(ready_pulses == N_CHARS - N_FIRST, $sformatf(
			"%0d ready pulses in total, expected %0d", ready_pulses, N_CHARS - N_FIRST));
		report_test(5, "credit limit and release");

		check_true(flowing, "no bits seen on the line");
		$display("Test 2 one D or S transition per bit: %0d errors", ds_errors);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: spw_tx.f
+incdir+design
design/spw_tx_pkg.sv
design/spw_tx_credit.sv
design/spw_tx_link_fsm.sv
design/spw_tx_char_shift.sv
design/spw_tx_ds_encoder.sv
design/spw_tx.sv
verif/spw_tx_ds_monitor.sv
verif/spw_tx_tb.sv

// File: Bender.yml
package:
  name: spw_tx

sources:
  - include_dirs:
      - design
    files:
      - design/spw_tx_pkg.sv
      - design/spw_tx_credit.sv
      - design/spw_tx_link_fsm.sv
      - design/spw_tx_char_shift.sv
      - design/spw_tx_ds_encoder.sv
      - design/spw_tx.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/spw_tx_ds_monitor.sv
      - verif/spw_tx_tb.sv
